//--- cpu_id_ex_patterns.txt
# cpu_en instr pc wb_en wb_addr wb_data | stall taken target alu waddr rw mw m2r undef
# one line per cycle, all hex; ex columns belong to the instruction of the line before
1 00000000 00000000 1 01 00000005 0 0 00000000 00000000 00 0 0 0 0
1 00000000 00000000 1 02 fffffff0 0 0 00000000 00000000 00 1 0 0 0
1 00000000 00000000 1 03 80000000 0 0 00000000 00000000 00 1 0 0 0
1 00222021 00000000 0 00 00000000 0 0 00000000 00000000 00 1 0 0 0
1 00222822 00000000 0 00 00000000 0 0 00000000 fffffff5 04 1 0 0 0
1 0041302a 00000000 0 00 00000000 0 0 00000000 00000015 05 1 0 0 0
1 0041382b 00000000 0 00 00000000 0 0 00000000 00000001 06 1 0 0 0
1 00034103 00000000 0 00 00000000 0 0 00000000 00000000 07 1 0 0 0
1 00034902 00000000 0 00 00000000 0 0 00000000 f8000000 08 1 0 0 0
1 000150c0 00000000 0 00 00000000 0 0 00000000 08000000 09 1 0 0 0
1 00225827 00000000 0 00 00000000 0 0 00000000 00000028 0a 1 0 0 0
1 202cfffd 00000000 0 00 00000000 0 0 00000000 0000000a 0b 1 0 0 0
1 304dff00 00000000 0 00 00000000 0 0 00000000 00000002 0c 1 0 0 0
1 342e8000 00000000 0 00 00000000 0 0 00000000 0000ff00 0d 1 0 0 0
1 3c0f1234 00000000 0 00 00000000 0 0 00000000 00008005 0e 1 0 0 0
1 2830ffff 00000000 0 00 00000000 0 0 00000000 12340000 0f 1 0 0 0
1 3851ffff 00000000 0 00 00000000 0 0 00000000 00000000 10 1 0 0 0
1 10210004 00000100 0 00 00000000 0 1 00000114 ffff000f 11 1 0 0 0
1 1422fffe 00000200 0 00 00000000 0 1 000001fc 00000000 00 0 0 0 0
1 10220001 00000300 0 00 00000000 0 0 00000000 00000015 00 0 0 0 0
1 14210001 00000300 0 00 00000000 0 0 00000000 00000015 00 0 0 0 0
1 08000040 10000000 0 00 00000000 0 1 10000100 00000000 00 0 0 0 0
1 0c000080 00000400 0 00 00000000 0 1 00000200 00000000 00 0 0 0 0
1 00000000 00000000 0 00 00000000 0 0 00000000 00000404 1f 1 0 0 0
1 8c250008 00000000 0 00 00000000 0 0 00000000 00000000 00 1 0 0 0
1 00a19021 00000000 0 00 00000000 1 0 00000000 0000000d 05 1 0 1 0
1 00a19021 00000000 0 00 00000000 0 0 00000000 00000000 00 0 0 0 0
1 8c200000 00000000 0 00 00000000 0 0 00000000 00000005 12 1 0 0 0
1 00019821 00000000 0 00 00000000 0 0 00000000 00000005 00 1 0 1 0
1 8c260000 00000000 0 00 00000000 0 0 00000000 00000005 13 1 0 0 0
1 0022a021 00000000 0 00 00000000 0 0 00000000 00000005 06 1 0 1 0
1 0000a825 00000000 1 00 deadbeef 0 0 00000000 fffffff5 14 1 0 0 0
1 0016b821 00000000 1 16 0000abcd 0 0 00000000 00000000 15 1 0 0 0
1 0016c021 00000000 0 00 00000000 0 0 00000000 0000abcd 17 1 0 0 0
1 fc000000 00000000 0 00 00000000 0 0 00000000 0000abcd 18 1 0 0 0
1 0000003f 00000000 0 00 00000000 0 0 00000000 00000000 00 0 0 0 1
1 ac410004 00000000 0 00 00000000 0 0 00000000 00000000 00 0 0 0 1
1 3c0f1234 00000000 0 00 00000000 0 0 00000000 fffffff4 00 0 1 0 0
0 00222021 00000000 0 00 00000000 0 0 00000000 12340000 0f 1 0 0 0
0 fc000000 00000000 0 00 00000000 0 0 00000000 12340000 0f 1 0 0 0
1 00000000 00000000 0 00 00000000 0 0 00000000 12340000 0f 1 0 0 0
1 00000000 00000000 0 00 00000000 0 0 00000000 00000000 00 1 0 0 0

//--- cpu_id_ex_properties.sv
`timescale 1ns/1ns

module cpu_id_ex_properties (
    input logic        clk,
    input logic        rst,
    input logic        cpu_en,
    input logic        stall,
    input logic [31:0] instruction,
    input logic [31:0] op_a,
    input logic [31:0] op_b,
    input logic [4:0]  write_addr,
    input logic        reg_write,
    input logic        mem_write,
    input logic        mem_to_reg,
    input logic        undefined
);

    hold_when_disabled: assert property (@(posedge clk) !cpu_en |=>
        $stable(instruction) && $stable(op_a) && $stable(op_b) && $stable(write_addr) &&
        $stable(reg_write) && $stable(mem_write) && $stable(mem_to_reg) && $stable(undefined))
        else $error("ID/EX register changed while cpu_en was low");

    bubble_on_stall: assert property (@(posedge clk) (cpu_en && stall) |=>
        !reg_write && !mem_write)
        else $error("stall did not insert a bubble");

    quiet_after_reset: assert property (@(posedge clk) (cpu_en && rst) |=>
        !reg_write && !mem_write && !mem_to_reg && !undefined)
        else $error("control outputs active after reset");

endmodule

bind id_ex_regs cpu_id_ex_properties i_props (
    .clk, .rst, .cpu_en, .stall,
    .instruction (bus_ex.instruction),
    .op_a        (bus_ex.op_a),
    .op_b        (bus_ex.op_b),
    .write_addr  (bus_ex.write_addr),
    .reg_write   (bus_ex.reg_write),
    .mem_write   (bus_ex.mem_write),
    .mem_to_reg  (bus_ex.mem_to_reg),
    .undefined   (bus_ex.undefined)
);

//--- cpu_id_ex_top.sv
`timescale 1ns/1ns

module cpu_id_ex_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_en,
    input  logic [31:0]                     id_instruction,
    input  logic [31:0]                     id_pc,
    input  logic                            wb_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [31:0]                     wb_data,
    output logic                            stall,
    output logic                            branch_taken,
    output logic [31:0]                     branch_target,
    output logic [31:0]                     ex_alu_result,
    output logic [31:0]                     ex_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_write_addr,
    output logic                            ex_reg_write,
    output logic                            ex_mem_write,
    output logic                            ex_mem_to_reg,
    output logic                            ex_undefined
);

    logic [mips_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [mips_pkg::REG_ADDR_W-1:0] rt_addr;
    logic [31:0]                     rs_data;
    logic [31:0]                     rt_data;

    id_ex_bus bus_id ();
    id_ex_bus bus_ex ();

    reg_file i_reg_file (
        .clk, .rst, .rs_addr, .rt_addr, .wb_addr, .wb_en, .wb_data, .rs_data, .rt_data
    );

    id_decode i_id_decode (
        .instruction (id_instruction),
        .pc          (id_pc),
        .rs_data, .rt_data, .rs_addr, .rt_addr,
        .bus_id      (bus_id.src),
        .bus_ex      (bus_ex.dst),
        .stall, .branch_taken, .branch_target
    );

    id_ex_regs i_id_ex_regs (
        .clk, .rst, .cpu_en, .stall,
        .bus_id (bus_id.dst),
        .bus_ex (bus_ex.src)
    );

    ex_stage i_ex_stage (
        .bus_ex     (bus_ex.dst),
        .alu_result (ex_alu_result),
        .store_data (ex_store_data)
    );

    assign ex_write_addr = bus_ex.write_addr;
    assign ex_reg_write  = bus_ex.reg_write;
    assign ex_mem_write  = bus_ex.mem_write;
    assign ex_mem_to_reg = bus_ex.mem_to_reg;
    assign ex_undefined  = bus_ex.undefined;

endmodule

//--- ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
    id_ex_bus.dst       bus_ex,
    output logic [31:0] alu_result,
    output logic [31:0] store_data
);

    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [4:0]  shift_count;

    assign alu_a       = bus_ex.a_use_shamt ? bus_ex.shift_amount : bus_ex.op_a;
    assign alu_b       = bus_ex.b_use_imm   ? bus_ex.immediate    : bus_ex.op_b;
    assign shift_count = alu_a[4:0];

    always_comb begin
        case (bus_ex.alu_op)
            mips_pkg::ALU_ADD:  alu_result = alu_a + alu_b;
            mips_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            mips_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            mips_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            mips_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            mips_pkg::ALU_NOR:  alu_result = ~(alu_a | alu_b);
            mips_pkg::ALU_SLT: begin
                alu_result = {31'd0, $signed(alu_a) < $signed(alu_b)};
            end
            mips_pkg::ALU_SLTU: begin
                alu_result = {31'd0, alu_a < alu_b};
            end
            mips_pkg::ALU_SLL:  alu_result = alu_b << shift_count;
            mips_pkg::ALU_SRL:  alu_result = alu_b >> shift_count;
            mips_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_b) >>> shift_count);
            mips_pkg::ALU_LUI:  alu_result = {alu_b[15:0], 16'd0};
            default:            alu_result = alu_a + alu_b;
        endcase
    end

    // rt value for sw, unaffected by the immediate select.
    assign store_data = bus_ex.op_b;

endmodule

//--- filelist.f
mips_pkg.sv
id_ex_bus.sv
reg_file.sv
id_decode.sv
id_ex_regs.sv
ex_stage.sv
cpu_id_ex_top.sv
cpu_id_ex_properties.sv
tb_checker.sv
tb_cpu_id_ex.sv

//--- id_decode.sv
`timescale 1ns/1ns

module id_decode (
    input  logic [31:0]                     instruction,
    input  logic [31:0]                     pc,
    input  logic [31:0]                     rs_data,
    input  logic [31:0]                     rt_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
    id_ex_bus.src                           bus_id,
    id_ex_bus.dst                           bus_ex,
    output logic                            stall,
    output logic                            branch_taken,
    output logic [31:0]                     branch_target
);

    mips_pkg::opcode_t               opcode;
    mips_pkg::funct_t                funct;
    logic [mips_pkg::REG_ADDR_W-1:0] rd;
    logic [mips_pkg::SHAMT_W-1:0]    shamt;
    logic [mips_pkg::IMM_W-1:0]      imm16;
    logic [31:0]                     imm_sext;
    logic [31:0]                     imm_zext;
    logic [31:0]                     pc_plus4;
    logic [31:0]                     branch_addr;
    logic [31:0]                     jump_addr;
    logic                            uses_rs;
    logic                            uses_rt;
    logic                            take;
    logic                            load_hit;

    assign opcode   = mips_pkg::opcode_t'(instruction[mips_pkg::OP_LSB +: mips_pkg::OPCODE_W]);
    assign funct    = mips_pkg::funct_t'(instruction[mips_pkg::FUNCT_LSB +: mips_pkg::FUNCT_W]);
    assign rs_addr  = instruction[mips_pkg::RS_LSB +: mips_pkg::REG_ADDR_W];
    assign rt_addr  = instruction[mips_pkg::RT_LSB +: mips_pkg::REG_ADDR_W];
    assign rd       = instruction[mips_pkg::RD_LSB +: mips_pkg::REG_ADDR_W];
    assign shamt    = instruction[mips_pkg::SHAMT_LSB +: mips_pkg::SHAMT_W];
    assign imm16    = instruction[mips_pkg::IMM_LSB +: mips_pkg::IMM_W];
    assign imm_sext = {{(32 - mips_pkg::IMM_W){imm16[mips_pkg::IMM_W-1]}}, imm16};
    assign imm_zext = {{(32 - mips_pkg::IMM_W){1'b0}}, imm16};
    assign pc_plus4 = pc + 32'd4;

    assign branch_addr = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign jump_addr   = {pc_plus4[31:28], instruction[mips_pkg::TARGET_W-1:0], 2'b00};

    always_comb begin
        bus_id.instruction  = instruction;
        bus_id.shift_amount = {{(32 - mips_pkg::SHAMT_W){1'b0}}, shamt};
        bus_id.immediate    = imm_sext;
        bus_id.op_a         = rs_data;
        bus_id.op_b         = rt_data;
        bus_id.alu_op       = mips_pkg::ALU_ADD;
        bus_id.write_addr   = '0;
        bus_id.reg_write    = 1'b0;
        bus_id.mem_write    = 1'b0;
        bus_id.a_use_shamt  = 1'b0;
        bus_id.mem_to_reg   = 1'b0;
        bus_id.b_use_imm    = 1'b0;
        bus_id.undefined    = 1'b0;
        uses_rs       = 1'b1;
        uses_rt       = 1'b0;
        take          = 1'b0;
        branch_target = branch_addr;

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                uses_rt           = 1'b1;
                bus_id.reg_write  = 1'b1;
                bus_id.write_addr = rd;
                case (funct)
                    mips_pkg::F_ADD, mips_pkg::F_ADDU: bus_id.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUB, mips_pkg::F_SUBU: bus_id.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  bus_id.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   bus_id.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_XOR:  bus_id.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::F_NOR:  bus_id.alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::F_SLT:  bus_id.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::F_SLTU: bus_id.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::F_SLL, mips_pkg::F_SRL, mips_pkg::F_SRA: begin
                        uses_rs            = 1'b0;      // shifts read rt only.
                        bus_id.a_use_shamt = 1'b1;
                        bus_id.alu_op      = (funct == mips_pkg::F_SLL) ? mips_pkg::ALU_SLL :
                                             (funct == mips_pkg::F_SRL) ? mips_pkg::ALU_SRL :
                                                                          mips_pkg::ALU_SRA;
                    end
                    default: begin
                        uses_rs           = 1'b0;
                        uses_rt           = 1'b0;
                        bus_id.reg_write  = 1'b0;
                        bus_id.write_addr = '0;
                        bus_id.undefined  = 1'b1;
                    end
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                bus_id.reg_write  = 1'b1;
                bus_id.write_addr = rt_addr;
                bus_id.b_use_imm  = 1'b1;
                case (opcode)
                    mips_pkg::OP_SLTI: bus_id.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_ANDI: bus_id.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  bus_id.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI: bus_id.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::OP_LUI: begin
                        uses_rs       = 1'b0;
                        bus_id.alu_op = mips_pkg::ALU_LUI;
                    end
                    default: bus_id.alu_op = mips_pkg::ALU_ADD;
                endcase
                // logical ops and lui take the immediate unsigned.
                if (opcode inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                                   mips_pkg::OP_XORI, mips_pkg::OP_LUI}) begin
                    bus_id.immediate = imm_zext;
                end
            end
            mips_pkg::OP_LW: begin
                bus_id.reg_write  = 1'b1;
                bus_id.mem_to_reg = 1'b1;
                bus_id.write_addr = rt_addr;
                bus_id.b_use_imm  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                uses_rt          = 1'b1;                // store data.
                bus_id.mem_write = 1'b1;
                bus_id.b_use_imm = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                uses_rt       = 1'b1;
                bus_id.alu_op = mips_pkg::ALU_SUB;
                take = (rs_data == rt_data) ^ (opcode == mips_pkg::OP_BNE);
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                uses_rs       = 1'b0;
                take          = 1'b1;
                branch_target = jump_addr;
                if (opcode == mips_pkg::OP_JAL) begin
                    bus_id.op_a       = pc_plus4;       // link value through the ALU.
                    bus_id.op_b       = '0;
                    bus_id.reg_write  = 1'b1;
                    bus_id.write_addr = mips_pkg::REG_ADDR_W'(mips_pkg::LINK_REG);
                end
            end
            default: begin
                uses_rs          = 1'b0;
                bus_id.undefined = 1'b1;
            end
        endcase
    end

    // load in EX whose result is needed here.
    assign load_hit = bus_ex.mem_to_reg && (bus_ex.write_addr != '0);
    assign stall    = load_hit && ((uses_rs && (bus_ex.write_addr == rs_addr)) ||
                                   (uses_rt && (bus_ex.write_addr == rt_addr)));

    assign branch_taken = take && !stall;

endmodule

//--- id_ex_bus.sv
`timescale 1ns/1ns

interface id_ex_bus;

    logic [31:0]                      instruction;
    logic [31:0]                      shift_amount;
    logic [31:0]                      immediate;
    logic [31:0]                      op_a;         // rs value, or pc+4 for jal.
    logic [31:0]                      op_b;         // rt value, or zero for jal.
    mips_pkg::alu_op_t                alu_op;
    logic [mips_pkg::REG_ADDR_W-1:0]  write_addr;
    logic                             reg_write;
    logic                             mem_write;
    logic                             a_use_shamt;
    logic                             mem_to_reg;
    logic                             b_use_imm;
    logic                             undefined;    // to the cp0 trap logic.

    modport src (
        output instruction, shift_amount, immediate, op_a, op_b, alu_op,
        output write_addr, reg_write, mem_write, a_use_shamt, mem_to_reg,
        output b_use_imm, undefined
    );

    modport dst (
        input instruction, shift_amount, immediate, op_a, op_b, alu_op,
        input write_addr, reg_write, mem_write, a_use_shamt, mem_to_reg,
        input b_use_imm, undefined
    );

endinterface

//--- id_ex_regs.sv
`timescale 1ns/1ns

module id_ex_regs (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_en,
    input  logic  stall,
    id_ex_bus.dst bus_id,
    id_ex_bus.src bus_ex
);

    // cpu_en low freezes the stage, reset and stall included.
    always_ff @(posedge clk) begin
        if (cpu_en) begin
            if (rst || stall) begin
                bus_ex.instruction  <= '0;
                bus_ex.shift_amount <= '0;
                bus_ex.immediate    <= '0;
                bus_ex.op_a         <= '0;
                bus_ex.op_b         <= '0;
                bus_ex.alu_op       <= mips_pkg::ALU_ADD;
                bus_ex.write_addr   <= '0;
                bus_ex.reg_write    <= 1'b0;
                bus_ex.mem_write    <= 1'b0;
                bus_ex.a_use_shamt  <= 1'b0;
                bus_ex.mem_to_reg   <= 1'b0;
                bus_ex.b_use_imm    <= 1'b0;
                bus_ex.undefined    <= 1'b0;
            end else begin
                bus_ex.instruction  <= bus_id.instruction;
                bus_ex.shift_amount <= bus_id.shift_amount;
                bus_ex.immediate    <= bus_id.immediate;
                bus_ex.op_a         <= bus_id.op_a;
                bus_ex.op_b         <= bus_id.op_b;
                bus_ex.alu_op       <= bus_id.alu_op;
                bus_ex.write_addr   <= bus_id.write_addr;
                bus_ex.reg_write    <= bus_id.reg_write;
                bus_ex.mem_write    <= bus_id.mem_write;
                bus_ex.a_use_shamt  <= bus_id.a_use_shamt;
                bus_ex.mem_to_reg   <= bus_id.mem_to_reg;
                bus_ex.b_use_imm    <= bus_id.b_use_imm;
                bus_ex.undefined    <= bus_id.undefined;
            end
        end
    end

endmodule

//--- mips_pkg.sv
package mips_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int LINK_REG   = 31;           // jal destination.

    // instruction field layout.
    localparam int OPCODE_W  = 6;
    localparam int FUNCT_W   = 6;
    localparam int SHAMT_W   = 5;
    localparam int IMM_W     = 16;
    localparam int TARGET_W  = 26;
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_LSB   = 0;

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [FUNCT_W-1:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_t;

    // zero must stay add so that a bubble computes 0 + 0.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

endpackage

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic                            wb_en,
    input  logic [31:0]                     wb_data,
    output logic [31:0]                     rs_data,
    output logic [31:0]                     rt_data
);

    logic [31:0] regs [1:mips_pkg::NUM_REGS-1];   // r0 has no storage.

    function automatic logic [31:0] read_port(input logic [mips_pkg::REG_ADDR_W-1:0] addr);
        logic [31:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_en && (wb_addr == addr)) begin
            value = wb_data;                       // same-cycle writeback bypass.
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_en,
    input  logic [31:0] instruction,
    input  logic        wb_en,
    input  logic [4:0]  wb_addr,
    input  logic [31:0] wb_data,
    input  logic        stall,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    input  logic [31:0] ex_alu_result,
    input  logic [31:0] ex_store_data,
    input  logic [4:0]  ex_write_addr,
    input  logic        ex_reg_write,
    input  logic        ex_mem_write,
    input  logic        ex_mem_to_reg,
    input  logic        ex_undefined,
    input  logic        exp_valid,
    input  logic        rand_mode,
    input  logic        exp_stall,
    input  logic        exp_taken,
    input  logic [31:0] exp_target,
    input  logic [31:0] exp_alu,
    input  logic [4:0]  exp_waddr,
    input  logic        exp_rw,
    input  logic        exp_mw,
    input  logic        exp_m2r,
    input  logic        exp_undef,
    output int          errors,
    output logic        pending
);

    logic [31:0] shadow [0:31];   // what the register file should hold.
    logic [31:0] predicted;
    logic [4:0]  rt;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            $display("Mismatch %s exp=%h got=%h at %0t", name, exp, got, $time);
            errors++;
        end
    endtask

    initial begin
        errors  = 0;
        pending = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        forever begin
            @(posedge clk);
            #3;                                   // just before the next edge.
            if (exp_valid) begin
                check_value("stall", 32'(exp_stall), 32'(stall));
                check_value("branch_taken", 32'(exp_taken), 32'(branch_taken));
                if (exp_taken) begin
                    check_value("branch_target", exp_target, branch_target);
                end
                check_value("ex_alu_result", exp_alu, ex_alu_result);
                check_value("ex_write_addr", 32'(exp_waddr), 32'(ex_write_addr));
                check_value("ex_reg_write", 32'(exp_rw), 32'(ex_reg_write));
                check_value("ex_mem_write", 32'(exp_mw), 32'(ex_mem_write));
                check_value("ex_mem_to_reg", 32'(exp_m2r), 32'(ex_mem_to_reg));
                check_value("ex_undefined", 32'(exp_undef), 32'(ex_undefined));
            end
            if (pending) begin
                check_value("ex_alu_result", predicted, ex_alu_result);
                check_value("ex_store_data", predicted, ex_store_data);
                pending = 1'b0;
            end
            // addu rd, r0, rt in decode: the result and the store data are the value of rt.
            if (rand_mode && cpu_en && instruction[31:26] == 6'h00 &&
                instruction[25:21] == 5'd0 && instruction[5:0] == 6'h21) begin
                rt = instruction[20:16];
                if (rt == 5'd0) predicted = '0;
                else if (wb_en && wb_addr == rt) predicted = wb_data;
                else predicted = shadow[rt];
                pending = 1'b1;
            end
            if (rst) begin
                for (int i = 0; i < 32; i++) begin
                    shadow[i] = '0;
                end
            end else if (wb_en && wb_addr != 5'd0) begin
                shadow[wb_addr] = wb_data;
            end
        end
    end

endmodule

//--- tb_cpu_id_ex.sv
`timescale 1ns/1ns

module tb_cpu_id_ex;

    localparam string PATTERN_FILE = "cpu_id_ex_patterns.txt";
    localparam int    MAX_LINES    = 500;
    localparam int    WAIT_LIMIT   = 20;       // cycles allowed for any wait.
    localparam int    RAND_ROUNDS  = 12;
    localparam logic [31:0] LFSR_SEED = 32'h8fa0;

    logic        clk;
    logic        rst;
    logic        cpu_en;
    logic [31:0] id_instruction;
    logic [31:0] id_pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        stall;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [31:0] ex_alu_result;
    logic [31:0] ex_store_data;
    logic [4:0]  ex_write_addr;
    logic        ex_reg_write;
    logic        ex_mem_write;
    logic        ex_mem_to_reg;
    logic        ex_undefined;

    // expected values handed to the checker.
    logic        exp_valid;
    logic        rand_mode;
    logic        exp_stall;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic [31:0] exp_alu;
    logic [4:0]  exp_waddr;
    logic        exp_rw;
    logic        exp_mw;
    logic        exp_m2r;
    logic        exp_undef;

    int          check_errors;
    logic        pending;
    int          other_errors;
    logic [31:0] lfsr_state;

    cpu_id_ex_top i_dut (
        .clk, .rst, .cpu_en, .id_instruction, .id_pc, .wb_en, .wb_addr, .wb_data,
        .stall, .branch_taken, .branch_target, .ex_alu_result, .ex_store_data,
        .ex_write_addr, .ex_reg_write, .ex_mem_write, .ex_mem_to_reg, .ex_undefined
    );

    tb_checker i_checker (
        .clk, .rst, .cpu_en, .instruction(id_instruction), .wb_en, .wb_addr, .wb_data,
        .stall, .branch_taken, .branch_target, .ex_alu_result, .ex_store_data,
        .ex_write_addr, .ex_reg_write, .ex_mem_write, .ex_mem_to_reg, .ex_undefined,
        .exp_valid, .rand_mode, .exp_stall, .exp_taken, .exp_target, .exp_alu,
        .exp_waddr, .exp_rw, .exp_mw, .exp_m2r, .exp_undef,
        .errors(check_errors), .pending
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_patterns();
        int    fd;
        int    lines;
        int    n;
        string text;
        logic [31:0] f [0:14];
        fd    = $fopen(PATTERN_FILE, "r");
        lines = 0;
        if (fd == 0) begin
            $display("could not open the pattern file %s", PATTERN_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd) && lines < MAX_LINES) begin
            text = "";
            void'($fgets(text, fd));
            lines++;
            if (text.len() < 2 || text[0] == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 15) begin
                $display("malformed pattern line %0d has %0d fields", lines, n);
                other_errors++;
                continue;
            end
            cpu_en = f[0][0];  id_instruction = f[1];  id_pc = f[2];
            wb_en  = f[3][0];  wb_addr = f[4][4:0];  wb_data = f[5];
            exp_stall = f[6][0];  exp_taken = f[7][0];  exp_target = f[8];
            exp_alu   = f[9];  exp_waddr = f[10][4:0];  exp_rw = f[11][0];
            exp_mw    = f[12][0];  exp_m2r = f[13][0];  exp_undef = f[14][0];
            exp_valid = 1'b1;
            next_cycle();
        end
        if (!$feof(fd)) begin
            $display("pattern file longer than %0d lines", MAX_LINES);
            other_errors++;
        end
        $fclose(fd);
        exp_valid = 1'b0;
    endtask

    // write a random register, then read it back through addu rd, r0, rt.
    task automatic random_readback();
        logic [31:0] addr;
        logic [31:0] data;
        rand_mode = 1'b1;
        cpu_en    = 1'b1;
        for (int i = 0; i < RAND_ROUNDS; i++) begin
            take_bits(5, addr);
            take_bits(32, data);
            wb_en = 1'b1;  wb_addr = addr[4:0];  wb_data = data;
            id_instruction = '0;
            next_cycle();
            wb_en = 1'b0;
            id_instruction = {6'h00, 5'd0, addr[4:0], 5'd25, 5'd0, 6'h21};
            next_cycle();
            id_instruction = '0;
            next_cycle();
        end
    endtask

    task automatic drain_checker();
        int n;
        n = 0;
        while (pending && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (pending) begin
            $display("timeout while waiting for the last readback check");
            other_errors++;
        end
    endtask

    initial begin
        rst = 1'b1;  cpu_en = 1'b1;
        id_instruction = '0;  id_pc = '0;
        wb_en = 1'b0;  wb_addr = '0;  wb_data = '0;
        exp_valid = 1'b0;  rand_mode = 1'b0;
        exp_stall = 1'b0;  exp_taken = 1'b0;  exp_target = '0;  exp_alu = '0;
        exp_waddr = '0;  exp_rw = 1'b0;  exp_mw = 1'b0;  exp_m2r = 1'b0;  exp_undef = 1'b0;
        other_errors = 0;
        lfsr_state   = LFSR_SEED;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        run_patterns();
        random_readback();
        drain_checker();
        next_cycle();

        $display("checker errors=%0d other errors=%0d", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
